/* posit_pkg.sv */
`default_nettype none

package posit_pkg;

    // ----------------------------------------
    // posit(8,2) format
    // ----------------------------------------
    localparam int POSIT_W   = 8;
    localparam int ES        = 2;
    localparam int FRAC_W    = POSIT_W - 3 - ES;         // longest fraction field
    localparam int MAX_SCALE = (1 << ES) * (POSIT_W - 2); // scale of maxpos
    localparam int SCALE_W   = 8;                         // holds +-(2*MAX_SCALE+1)

    typedef logic [POSIT_W-1:0]        posit_t;  // encoded posit
    typedef logic signed [SCALE_W-1:0] scale_t;  // power of two
    typedef logic [FRAC_W-1:0]         frac_t;   // hidden bit left out

    // one operand after decoding
    typedef struct packed {
        logic   sign;
        logic   zero;
        logic   nar;
        scale_t scale;
        frac_t  frac;   // left aligned
    } posit_dec_t;

    // ----------------------------------------
    // special encodings
    // ----------------------------------------
    localparam posit_t MAXPOS_ENC       = 8'h7F;
    localparam posit_t MINUS_MAXPOS_ENC = 8'h81;
    localparam posit_t NAR_ENC          = 8'h80;

endpackage

`default_nettype wire

/* mac_pkg.sv */
`default_nettype none

package mac_pkg;

    // product mantissa is (1.f)*(1.f), format xx.ffffff
    localparam int PROD_MANT_W = 2 * (posit_pkg::FRAC_W + 1);

    // quire layout, LSB weighs 2^-QUIRE_FRAC
    localparam int QUIRE_FRAC  = 2 * posit_pkg::MAX_SCALE + 2 * posit_pkg::FRAC_W;
    localparam int QUIRE_INT   = 2 * posit_pkg::MAX_SCALE + 3;  // weights 2^0 .. 2^50
    localparam int QUIRE_GUARD = 8;                              // carry room for long sums
    localparam int QUIRE_W     = 1 + QUIRE_GUARD + QUIRE_INT + QUIRE_FRAC;

    typedef logic signed [QUIRE_W-1:0] quire_t;
    typedef logic [PROD_MANT_W-1:0]    mant_t;

    // exact product of one pair
    typedef struct packed {
        logic              zero;   // zero or NaR operand
        logic              sign;
        posit_pkg::scale_t scale;
        mant_t             mant;
    } prod_t;

endpackage

`default_nettype wire

/* lzc.sv */
`default_nettype none

module lzc #(
    parameter int IN_W = 8
) (
    input  logic [IN_W-1:0]            in_i,
    output logic [$clog2(IN_W+1)-1:0]  cnt_o,
    output logic                       all_zero_o
);

    localparam int CNT_W = $clog2(IN_W + 1);

    // highest set bit wins, so scan upward and keep overwriting
    always_comb begin
        cnt_o = CNT_W'(IN_W);  // all zero
        for (int i = 0; i < IN_W; i++) begin
            if (in_i[i]) begin
                cnt_o = CNT_W'(IN_W - 1 - i);
            end
        end
    end

    assign all_zero_o = ~|in_i;

endmodule

`default_nettype wire

/* posit_decoder.sv */
`default_nettype none

module posit_decoder (
    input  posit_pkg::posit_t     p_i,
    output posit_pkg::posit_dec_t dec_o
);

    import posit_pkg::*;

    localparam int BODY_W = POSIT_W - 1;
    localparam int CNT_W  = $clog2(BODY_W + 1);

    posit_t            p_abs;
    logic [BODY_W-1:0] body;
    logic [BODY_W-1:0] run_inv;   // regime run turned into leading zeros
    logic [CNT_W-1:0]  run_len;
    logic [BODY_W-1:0] rem;       // bits after regime terminator
    scale_t            regime;
    logic [ES-1:0]     exp_bits;

    assign p_abs   = p_i[POSIT_W-1] ? -p_i : p_i;
    assign body    = p_abs[BODY_W-1:0];
    assign run_inv = body[BODY_W-1] ? ~body : body;

    lzc #(
        .IN_W (FRAC_W + 4)
    ) u_lzc (
        .in_i       (run_inv),
        .cnt_o      (run_len),
        .all_zero_o ()
    );

    // drop the run and its terminator, missing bits shift in as zero
    assign rem = body << ({1'b0, run_len} + 1'b1);

    assign regime   = body[BODY_W-1] ? scale_t'(run_len) - scale_t'(1) : -scale_t'(run_len);
    assign exp_bits = rem[BODY_W-1 -: ES];

    always_comb begin
        dec_o.sign  = p_i[POSIT_W-1];
        dec_o.zero  = (p_i == '0);
        dec_o.nar   = (p_i == NAR_ENC);
        dec_o.scale = (regime <<< ES) + scale_t'(exp_bits);  // useed^k * 2^e
        dec_o.frac  = rem[BODY_W-1-ES -: FRAC_W];
    end

endmodule

`default_nettype wire

/* posit_multiplier.sv */
`default_nettype none

module posit_multiplier (
    input  logic              clk_i,
    input  logic              rstn,
    input  logic              vld_i,
    input  posit_pkg::posit_t win_i,
    input  posit_pkg::posit_t din_i,
    output mac_pkg::prod_t    prod_o,
    output logic              prod_vld_o
);

    import posit_pkg::*;
    import mac_pkg::*;

    posit_t     win_q;
    posit_t     din_q;
    logic       in_vld_q;
    posit_dec_t w_dec;
    posit_dec_t d_dec;
    posit_dec_t w_dec_q;
    posit_dec_t d_dec_q;
    logic       dec_vld_q;
    logic       zero_op;
    mant_t      mant;

    // ----------------------------------------
    // input capture and decode
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (vld_i) begin
            win_q <= win_i;
            din_q <= din_i;
        end
    end

    posit_decoder u_dec_w (
        .p_i   (win_q),
        .dec_o (w_dec)
    );

    posit_decoder u_dec_d (
        .p_i   (din_q),
        .dec_o (d_dec)
    );

    always_ff @(posedge clk_i) begin
        if (in_vld_q) begin
            w_dec_q <= w_dec;
            d_dec_q <= d_dec;
        end
    end

    // ----------------------------------------
    // exact product
    // ----------------------------------------
    assign zero_op = w_dec_q.zero | w_dec_q.nar | d_dec_q.zero | d_dec_q.nar;
    assign mant    = mant_t'({1'b1, w_dec_q.frac}) * mant_t'({1'b1, d_dec_q.frac});

    always_ff @(posedge clk_i) begin
        if (dec_vld_q) begin
            prod_o.zero  <= zero_op;  // NaR counts as zero
            prod_o.sign  <= w_dec_q.sign ^ d_dec_q.sign;
            prod_o.scale <= w_dec_q.scale + d_dec_q.scale;
            prod_o.mant  <= mant;     // 01.xxxxxx to 11.xxxxxx
        end
    end

    always_ff @(posedge clk_i or negedge rstn) begin
        if (!rstn) begin
            in_vld_q   <= 1'b0;
            dec_vld_q  <= 1'b0;
            prod_vld_o <= 1'b0;
        end else begin
            in_vld_q   <= vld_i;
            dec_vld_q  <= in_vld_q;
            prod_vld_o <= dec_vld_q;
        end
    end

endmodule

`default_nettype wire

/* quire_accumulator.sv */
`default_nettype none

module quire_accumulator #(
    parameter int DOT_LEN = 4
) (
    input  logic            clk_i,
    input  logic            rstn,
    input  mac_pkg::prod_t  prod_i,
    input  logic            prod_vld_i,
    output mac_pkg::quire_t sum_o,
    output logic            sum_vld_o
);

    import posit_pkg::*;
    import mac_pkg::*;

    localparam int SH_W  = $clog2(QUIRE_W);
    localparam int CNT_W = $clog2(DOT_LEN + 1);

    quire_t           quire;
    quire_t           aligned;
    quire_t           addend;
    quire_t           quire_nxt;
    logic [SH_W-1:0]  shamt;
    logic [CNT_W-1:0] pair_cnt;
    logic             last_pair;

    // ----------------------------------------
    // align product to quire
    // ----------------------------------------
    // mant LSB weighs 2^(scale-6), quire LSB weighs 2^-54
    assign shamt   = SH_W'(prod_i.scale + scale_t'(2 * MAX_SCALE));
    assign aligned = quire_t'(prod_i.mant) << shamt;

    always_comb begin
        if (prod_i.zero) begin
            addend = '0;
        end else if (prod_i.sign) begin
            addend = -aligned;
        end else begin
            addend = aligned;
        end
    end

    assign quire_nxt = quire + addend;
    assign last_pair = (pair_cnt == CNT_W'(DOT_LEN - 1));

    // ----------------------------------------
    // accumulate and hand off
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rstn) begin
        if (!rstn) begin
            quire     <= '0;
            pair_cnt  <= '0;
            sum_vld_o <= 1'b0;
        end else begin
            sum_vld_o <= 1'b0;
            if (prod_vld_i) begin
                if (last_pair) begin
                    quire     <= '0;    // next dot product starts clean
                    pair_cnt  <= '0;
                    sum_vld_o <= 1'b1;
                end else begin
                    quire    <= quire_nxt;
                    pair_cnt <= pair_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (prod_vld_i && last_pair) begin
            sum_o <= quire_nxt;  // includes the closing product
        end
    end

    a_cnt_range : assert property (
        @(posedge clk_i) disable iff (!rstn) pair_cnt < CNT_W'(DOT_LEN)
    );

endmodule

`default_nettype wire

/* quire_to_posit.sv */
`default_nettype none

module quire_to_posit (
    input  logic              clk_i,
    input  logic              rstn,
    input  mac_pkg::quire_t   sum_i,
    input  logic              sum_vld_i,
    output posit_pkg::posit_t acc_o,
    output logic              vld_o
);

    import posit_pkg::*;
    import mac_pkg::*;

    localparam int LZ_W   = $clog2(QUIRE_W + 1);
    localparam int KEEP_W = FRAC_W + 1;      // widest fraction plus one
    localparam int BODY_W = POSIT_W - 1;
    localparam int ENC_W  = 2 * POSIT_W;

    logic               neg;
    logic [QUIRE_W-1:0] mag;
    logic [QUIRE_W-1:0] norm;
    logic [LZ_W-1:0]    lz;
    logic               mag_zero;
    scale_t             scale;

    logic               sign_q;
    logic               zero_q;
    logic               ovf_q;
    logic               udf_q;
    scale_t             scale_q;
    logic [KEEP_W-1:0]  frac_q;
    logic               sticky_q;
    logic               norm_vld_q;

    scale_t                  regime;
    scale_t                  run_sh;
    logic [ES-1:0]           exp_bits;
    logic                    reg_neg;
    logic signed [ENC_W-1:0] enc_base;
    logic signed [ENC_W-1:0] enc_sh;
    logic [BODY_W-1:0]       body;
    logic                    guard;
    logic                    sticky;
    logic                    round_up;
    logic [BODY_W-1:0]       body_rnd;
    posit_t                  pos_val;
    posit_t                  enc_out;

    // ----------------------------------------
    // stage 1: magnitude and normalize
    // ----------------------------------------
    assign neg  = sum_i[QUIRE_W-1];
    assign mag  = neg ? -sum_i : sum_i;

    lzc #(
        .IN_W (QUIRE_W)
    ) u_lzc (
        .in_i       (mag),
        .cnt_o      (lz),
        .all_zero_o (mag_zero)
    );

    assign norm  = mag << lz;  // leading one at MSB
    assign scale = scale_t'(QUIRE_W - 1 - QUIRE_FRAC) - scale_t'(lz);

    always_ff @(posedge clk_i) begin
        if (sum_vld_i) begin
            sign_q   <= neg;
            zero_q   <= mag_zero;
            ovf_q    <= !mag_zero && (scale > scale_t'(MAX_SCALE));
            udf_q    <= !mag_zero && (scale < -scale_t'(MAX_SCALE));
            scale_q  <= scale;
            frac_q   <= norm[QUIRE_W-2 -: KEEP_W];
            sticky_q <= |norm[QUIRE_W-2-KEEP_W:0];
        end
    end

    // ----------------------------------------
    // stage 2: encode and round
    // ----------------------------------------
    assign regime   = scale_q >>> ES;
    assign exp_bits = scale_q[ES-1:0];
    assign reg_neg  = regime[$bits(scale_t)-1];
    assign run_sh   = reg_neg ? -regime - scale_t'(1) : regime;

    // arithmetic shift stretches the leading regime bit into the run
    assign enc_base = {~reg_neg, reg_neg, exp_bits, frac_q, {(ENC_W-2-ES-KEEP_W){1'b0}}};
    assign enc_sh   = enc_base >>> run_sh;

    assign body     = enc_sh[ENC_W-1 -: BODY_W];
    assign guard    = enc_sh[ENC_W-1-BODY_W];
    assign sticky   = (|enc_sh[ENC_W-2-BODY_W:0]) | sticky_q;
    assign round_up = guard & (body[0] | sticky) & ~&body;  // never past maxpos
    assign body_rnd = body + BODY_W'(round_up);
    assign pos_val  = {1'b0, body_rnd};

    always_comb begin
        if (ovf_q) begin
            enc_out = sign_q ? MINUS_MAXPOS_ENC : MAXPOS_ENC;
        end else if (udf_q || zero_q) begin
            enc_out = '0;
        end else begin
            enc_out = sign_q ? -pos_val : pos_val;
        end
    end

    always_ff @(posedge clk_i or negedge rstn) begin
        if (!rstn) begin
            norm_vld_q <= 1'b0;
            vld_o      <= 1'b0;
            acc_o      <= '0;
        end else begin
            norm_vld_q <= sum_vld_i;
            vld_o      <= norm_vld_q;
            if (norm_vld_q) begin
                acc_o <= enc_out;
            end
        end
    end

    // a finished sum is always a real number
    a_no_nar : assert property (
        @(posedge clk_i) disable iff (!rstn)
        vld_o |-> (acc_o != NAR_ENC)
    );

endmodule

`default_nettype wire

/* posit_mac_top.sv */
`default_nettype none

module posit_mac_top #(
    parameter int DOT_LEN = 4
) (
    input  logic              clk_i,
    input  logic              rstn,
    input  logic              vld_i,
    input  posit_pkg::posit_t win_i,
    input  posit_pkg::posit_t din_i,
    output posit_pkg::posit_t acc_o,
    output logic              vld_o
);

    import mac_pkg::*;

    prod_t  prod;
    logic   prod_vld;
    quire_t sum;
    logic   sum_vld;

    // ----------------------------------------
    // decode and multiply
    // ----------------------------------------
    posit_multiplier u_posit_multiplier (
        .clk_i      (clk_i),
        .rstn       (rstn),
        .vld_i      (vld_i),
        .win_i      (win_i),
        .din_i      (din_i),
        .prod_o     (prod),
        .prod_vld_o (prod_vld)
    );

    // ----------------------------------------
    // accumulate
    // ----------------------------------------
    quire_accumulator #(
        .DOT_LEN (DOT_LEN)
    ) u_quire_accumulator (
        .clk_i      (clk_i),
        .rstn       (rstn),
        .prod_i     (prod),
        .prod_vld_i (prod_vld),
        .sum_o      (sum),
        .sum_vld_o  (sum_vld)
    );

    // ----------------------------------------
    // back to posit
    // ----------------------------------------
    quire_to_posit u_quire_to_posit (
        .clk_i     (clk_i),
        .rstn      (rstn),
        .sum_i     (sum),
        .sum_vld_i (sum_vld),
        .acc_o     (acc_o),
        .vld_o     (vld_o)
    );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD = 20,
    parameter int RST_CYCLES  = 3
) (
    output logic clk_o,
    output logic rstn_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #HALF_PERIOD;
            clk_o = ~clk_o;
        end
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rstn_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rstn_o <= 1'b1;
    end

endmodule

`default_nettype wire

/* tb_vectors.svh */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// one row per dot product
//   w, d : four operand pairs, applied in order 0 to 3
//   res  : expected posit(8,2) result
//   gap  : largest random idle gap after each pair
typedef struct packed {
    posit_t [0:3] w;
    posit_t [0:3] d;
    posit_t       res;
    logic [3:0]   gap;
} row_t;

localparam int NUM_ROWS = 17;

localparam row_t ROWS [NUM_ROWS] = '{
    // zero and NaR operands
    '{{8'h00, 8'h00, 8'h00, 8'h00}, {8'h00, 8'h00, 8'h00, 8'h00}, 8'h00, 4'd0},
    '{{8'h80, 8'h40, 8'h80, 8'h00}, {8'h40, 8'h80, 8'h80, 8'h00}, 8'h00, 4'd2},
    // exact sums
    '{{8'h40, 8'h40, 8'h40, 8'h40}, {8'h40, 8'h40, 8'h40, 8'h40}, 8'h50, 4'd1},
    '{{8'h40, 8'hC0, 8'h40, 8'h00}, {8'h40, 8'h40, 8'hC0, 8'h40}, 8'hC0, 4'd3},
    '{{8'h48, 8'h40, 8'h00, 8'h00}, {8'h48, 8'h40, 8'h00, 8'h00}, 8'h52, 4'd0},
    '{{8'h44, 8'h00, 8'h00, 8'h00}, {8'h44, 8'h00, 8'h00, 8'h00}, 8'h49, 4'd0},
    '{{8'h74, 8'h40, 8'h00, 8'h00}, {8'h40, 8'h74, 8'h00, 8'h00}, 8'h76, 4'd2},
    '{{8'h80, 8'h40, 8'h00, 8'h00}, {8'h40, 8'h40, 8'h00, 8'h00}, 8'h40, 4'd0},
    // cancellation through large values
    '{{8'h7F, 8'h81, 8'h00, 8'h00}, {8'h7F, 8'h7F, 8'h00, 8'h00}, 8'h00, 4'd1},
    // saturation and flush
    '{{8'h7F, 8'h00, 8'h00, 8'h00}, {8'h7F, 8'h00, 8'h00, 8'h00}, 8'h7F, 4'd0},
    '{{8'h81, 8'h00, 8'h00, 8'h00}, {8'h7F, 8'h00, 8'h00, 8'h00}, 8'h81, 4'd4},
    '{{8'h01, 8'h00, 8'h00, 8'h00}, {8'h01, 8'h00, 8'h00, 8'h00}, 8'h00, 4'd0},
    '{{8'h01, 8'h00, 8'h00, 8'h00}, {8'h40, 8'h00, 8'h00, 8'h00}, 8'h01, 4'd2},
    // ties go to even, above the tie goes up
    '{{8'h40, 8'h20, 8'h00, 8'h00}, {8'h40, 8'h40, 8'h00, 8'h00}, 8'h40, 4'd0},
    '{{8'h40, 8'h20, 8'h10, 8'h00}, {8'h40, 8'h40, 8'h40, 8'h00}, 8'h41, 4'd3},
    '{{8'h41, 8'h20, 8'h00, 8'h00}, {8'h40, 8'h40, 8'h00, 8'h00}, 8'h42, 4'd0},
    '{{8'hBF, 8'hE0, 8'h00, 8'h00}, {8'h40, 8'h40, 8'h00, 8'h00}, 8'hBE, 4'd1}
};

`endif

/* tb_posit_mac.sv */
`default_nettype none

module tb_posit_mac;

    import posit_pkg::*;

    localparam int          DOT_LEN  = 4;
    localparam int          LATENCY  = 5;    // last pair sampled to vld_o
    localparam int          MAX_WAIT = 100;  // cycles per result
    localparam int          RST_WAIT = 10;
    localparam int          TAIL_CYC = 12;
    localparam int unsigned SEED     = 32'h2bda0758;

    `include "tb_vectors.svh"

    logic   clk;
    logic   rstn;
    logic   vld;
    posit_t win;
    posit_t din;
    posit_t acc;
    logic   acc_vld;

    int unsigned cycle_cnt = 0;
    int unsigned err_cnt;
    int unsigned row_cnt;
    logic        timed_out;
    int unsigned sample_q[$];  // edge that took each row's last pair

    tb_clock_gen u_tb_clock_gen (
        .clk_o  (clk),
        .rstn_o (rstn)
    );

    posit_mac_top #(
        .DOT_LEN (DOT_LEN)
    ) u_posit_mac_top (
        .clk_i (clk),
        .rstn  (rstn),
        .vld_i (vld),
        .win_i (win),
        .din_i (din),
        .acc_o (acc),
        .vld_o (acc_vld)
    );

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    task automatic drive_pair(input posit_t w, input posit_t d);
        @(negedge clk);
        vld = 1'b1;
        win = w;
        din = d;
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            vld = 1'b0;
        end
    endtask

    task automatic drive_rows();
        int gap;
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int i = 0; i < DOT_LEN; i++) begin
                drive_pair(ROWS[r].w[i], ROWS[r].d[i]);
                if (i == DOT_LEN - 1) begin
                    sample_q.push_back(cycle_cnt + 1);  // taken on next rising edge
                end
                gap = int'($urandom_range(int'(ROWS[r].gap), 0));
                idle_cycles(gap);
            end
        end
        idle_cycles(1);
    endtask

    // ----------------------------------------
    // response checking
    // ----------------------------------------
    task automatic wait_result(output logic seen);
        int n;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < MAX_WAIT) begin
            @(negedge clk);
            seen = acc_vld;
            n++;
        end
    endtask

    task automatic check_rows();
        logic        seen;
        logic        row_ok;
        int unsigned smp;
        int unsigned lat;
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (!timed_out) begin
                wait_result(seen);
                if (!seen) begin
                    $display("timeout: no vld_o pulse for row %0d within %0d cycles",
                             r, MAX_WAIT);
                    timed_out = 1'b1;
                end else begin
                    row_ok = 1'b1;
                    lat    = 0;
                    if (sample_q.size() == 0) begin
                        $display("row %0d: vld_o pulsed before its last pair was driven", r);
                        row_ok = 1'b0;
                        err_cnt++;
                    end else begin
                        smp = sample_q.pop_front();
                        lat = cycle_cnt - smp;
                        assert (lat == LATENCY) else begin
                            $display("FAILED at %0t: row %0d latency %0d expected %0d",
                                     $time, r, lat, LATENCY);
                            row_ok = 1'b0;
                            err_cnt++;
                        end
                    end
                    assert (acc == ROWS[r].res) else begin
                        $display("FAILED at %0t: row %0d acc_o %h expected %h",
                                 $time, r, acc, ROWS[r].res);
                        row_ok = 1'b0;
                        err_cnt++;
                    end
                    row_cnt++;
                    $display("row %0d: acc_o %h expected %h latency %0d %s",
                             r, acc, ROWS[r].res, lat, row_ok ? "ok" : "bad");
                    @(negedge clk);
                    assert (!acc_vld) else begin  // single cycle pulse
                        $display("FAILED at %0t: row %0d vld_o high for more than one cycle",
                                 $time, r);
                        err_cnt++;
                    end
                end
            end
        end
    endtask

    // no stray pulses once the table is done
    task automatic check_quiet();
        for (int i = 0; i < TAIL_CYC; i++) begin
            @(negedge clk);
            assert (!acc_vld) else begin
                $display("FAILED at %0t: extra vld_o pulse after last row", $time);
                err_cnt++;
            end
        end
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        logic rst_done;
        int   n;
        vld       = 1'b0;
        win       = '0;
        din       = '0;
        err_cnt   = 0;
        row_cnt   = 0;
        timed_out = 1'b0;
        void'($urandom(SEED));

        rst_done = 1'b0;
        n        = 0;
        while (!rst_done && n < RST_WAIT) begin
            @(negedge clk);
            if (rstn) begin
                rst_done = 1'b1;
            end else begin
                assert (!acc_vld) else begin
                    $display("FAILED at %0t: vld_o high during reset", $time);
                    err_cnt++;
                end
            end
            n++;
        end

        if (!rst_done) begin
            $display("timeout: reset was never released");
            timed_out = 1'b1;
        end else begin
            fork
                drive_rows();
                check_rows();
            join
            check_quiet();
        end

        $display("%0d of %0d rows checked, %0d checks failed", row_cnt, NUM_ROWS, err_cnt);
        if (err_cnt == 0 && !timed_out) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+.
posit_pkg.sv
mac_pkg.sv
lzc.sv
posit_decoder.sv
posit_multiplier.sv
quire_accumulator.sv
quire_to_posit.sv
posit_mac_top.sv
tb_clock_gen.sv
tb_posit_mac.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module tb_posit_mac -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -qx "Test OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
